// File: flist.f
+incdir+rtl
rtl/hist_pkg.sv
rtl/hist_bank_ram.sv
rtl/hist_builder.sv
rtl/hist_readout.sv
rtl/hist_top.sv
tb/tb_hist_top.sv

// File: Makefile
# Verilator build and run of the histogram engine testbench

TOP := tb_hist_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

# the run fails unless the pass line shows up in the output
test:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tb/tb_hist_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "hist_params.svh"

module tb_hist_top;

    localparam int DEPTH = `HIST_PIXEL_NUM * `HIST_BIN_NUM;
    localparam int FRAME_HITS = `HIST_PIXEL_NUM * `HIST_ACQ_NUM;
    localparam int COUNT_MAX = (1 << `HIST_COUNT_W) - 1;

    // ways to pick the bin of each driven hit
    localparam int BIN_RANDOM = 0;
    localparam int BIN_FIXED = 1;
    localparam int BIN_ROUND = 2;
    localparam int BIN_HALF_ROUND = 3;

    // hits and frames of all tests sizing the watchdog
    localparam int HIT_TOTAL = 32 + 32 + 64 + 32 + 136 + 320;
    localparam int FRAME_TOTAL = 18;
    localparam int WATCHDOG_CYCLES = HIT_TOTAL * 2 + FRAME_TOTAL * 70 + 100;

    logic clk = 1'b0;
    logic res;
    logic hit_valid;
    hist_pkg::bin_t hit_bin;
    logic hit_drop;
    logic frame_done;
    logic out_valid;
    hist_pkg::pixel_t out_pixel;
    hist_pkg::bin_t out_bin;
    hist_pkg::count_t out_count;
    logic out_last;

    int seed = 54179;

    // reference model state owned by the compare process
    hist_pkg::count_t model_mem [0:DEPTH-1];
    hist_pkg::count_t exp_q [$];
    hist_pkg::pixel_t model_pixel = '0;
    hist_pkg::addr_t model_addr;
    hist_pkg::count_t exp_count;
    int model_cnt = 0;
    logic last_valid = 1'b0;
    hist_pkg::bin_t last_bin = '0;
    int beat_idx = 0;
    int frames_done_cnt = 0;
    int frames_read_cnt = 0;
    int drop_cnt = 0;
    int chk_cnt = 0;
    int err_cnt = 0;

    // failures noticed by the stimulus process
    int seq_err_cnt = 0;

    always #20 clk = ~clk;

    hist_top i_hist_top (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .hit_drop   (hit_drop),
        .frame_done (frame_done),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_last   (out_last)
    );

    // one more count in a bin held at the top of the range
    function automatic hist_pkg::count_t next_count(input hist_pkg::count_t cur);
        int sum;
        sum = int'(cur) + 1;
        if (sum > COUNT_MAX) begin
            sum = COUNT_MAX;
        end
        return hist_pkg::count_t'(sum);
    endfunction

    function automatic int total_errors();
        return err_cnt + seq_err_cnt;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic check_count(input string name, input hist_pkg::count_t got,
                               input hist_pkg::count_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input hist_pkg::pixel_t got_pixel, input hist_pkg::bin_t got_bin,
                              input hist_pkg::pixel_t exp_pixel, input hist_pkg::bin_t exp_bin);
        chk_cnt++;
        if (got_pixel !== exp_pixel) begin
            $display("ERROR out_pixel: got 0x%0h, expected 0x%0h", got_pixel, exp_pixel);
            err_cnt++;
        end
        if (got_bin !== exp_bin) begin
            $display("ERROR out_bin: got 0x%0h, expected 0x%0h", got_bin, exp_bin);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    // model and compare on the falling edge where all outputs are settled
    always @(negedge clk) begin
        if (!res) begin
            // reference starts empty like both banks after reset
            for (int i = 0; i < DEPTH; i++) begin
                model_mem[i] = '0;
            end
        end else begin
            // frame boundary first since a hit seen now already belongs to the next frame
            if (frame_done) begin
                frames_done_cnt++;
                if (model_cnt != FRAME_HITS) begin
                    report_failure($sformatf("frame_done after %0d accepted hits instead of %0d",
                                             model_cnt, FRAME_HITS));
                end
                // swap only once the previous readout is over
                check_flag("out_valid at frame_done", out_valid, 1'b0);
                for (int i = 0; i < DEPTH; i++) begin
                    exp_q.push_back(model_mem[i]);
                    model_mem[i] = '0;
                end
                model_cnt = 0;
            end
            // hit of the previous cycle is dropped if hit_drop shows now
            if (last_valid) begin
                if (hit_drop) begin
                    drop_cnt++;
                end else begin
                    model_addr = {model_pixel, last_bin};
                    model_mem[model_addr] = next_count(model_mem[model_addr]);
                    model_pixel = model_pixel + hist_pkg::pixel_t'(1);
                    model_cnt++;
                end
            end else if (hit_drop) begin
                report_failure("hit_drop pulsed without a hit in the cycle before");
            end
            last_valid = hit_valid;
            last_bin = hit_bin;
            // readout beats in pixel-major then bin order
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("output beat while no finished frame was expected");
                end else begin
                    exp_count = exp_q.pop_front();
                    check_count("out_count", out_count, exp_count);
                    check_addr(out_pixel, out_bin, hist_pkg::pixel_t'(beat_idx / `HIST_BIN_NUM),
                               hist_pkg::bin_t'(beat_idx % `HIST_BIN_NUM));
                    check_flag("out_last", out_last, beat_idx == DEPTH - 1);
                end
                if (beat_idx == DEPTH - 1) begin
                    beat_idx = 0;
                    frames_read_cnt++;
                end else begin
                    beat_idx++;
                end
            end else if (beat_idx != 0) begin
                report_failure($sformatf("out_valid fell after %0d of %0d beats", beat_idx, DEPTH));
                beat_idx = 0;
            end
        end
    end

    task automatic drive_hits(input int n, input int mode, input hist_pkg::bin_t fixed_bin,
                              input int max_gap);
        int gap;
        hist_pkg::bin_t b;
        for (int i = 0; i < n; i++) begin
            case (mode)
                BIN_RANDOM: b = hist_pkg::bin_t'($random(seed));
                BIN_FIXED: b = fixed_bin;
                BIN_ROUND: b = hist_pkg::bin_t'(i / `HIST_PIXEL_NUM);
                default: b = hist_pkg::bin_t'(i / (2 * `HIST_PIXEL_NUM));
            endcase
            gap = 0;
            if (max_gap > 0) begin
                gap = int'($unsigned($random(seed)) % (max_gap + 1));
            end
            @(posedge clk);
            hit_valid <= 1'b1;
            hit_bin <= b;
            repeat (gap) begin
                @(posedge clk);
                hit_valid <= 1'b0;
            end
        end
        @(posedge clk);
        hit_valid <= 1'b0;
    endtask

    // top up a frame that lost hits to drops
    task automatic complete_frame();
        repeat (3) @(posedge clk);
        while (model_cnt != 0 && model_cnt < FRAME_HITS) begin
            drive_hits(FRAME_HITS - model_cnt, BIN_RANDOM, '0, 0);
            repeat (3) @(posedge clk);
        end
    endtask

    // all frames swapped and fully read out
    task automatic wait_idle();
        repeat (3) @(posedge clk);
        while (!(model_cnt == 0 && exp_q.size() == 0 && beat_idx == 0 &&
                 frames_read_cnt == frames_done_cnt)) begin
            @(posedge clk);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    initial begin
        int errs_before;
        int drops_before;
        res = 1'b0;
        hit_valid = 1'b0;
        hit_bin = '0;
        repeat (5) @(posedge clk);
        res <= 1'b1;
        repeat (2) @(posedge clk);

        errs_before = total_errors();
        drive_hits(FRAME_HITS, BIN_RANDOM, '0, 3);
        wait_idle();
        end_test("1 sparse frame", errs_before);

        // same bin in two rounds in a row with no idle cycle
        errs_before = total_errors();
        drive_hits(FRAME_HITS, BIN_HALF_ROUND, '0, 0);
        wait_idle();
        end_test("2 back-to-back forced bins", errs_before);

        errs_before = total_errors();
        drive_hits(2 * FRAME_HITS, BIN_FIXED, hist_pkg::bin_t'(9), 0);
        wait_idle();
        end_test("3 saturation", errs_before);

        // bin 9 of both banks was full and must read back as zero
        errs_before = total_errors();
        drive_hits(FRAME_HITS, BIN_ROUND, '0, 0);
        wait_idle();
        end_test("4 clear between frames", errs_before);

        errs_before = total_errors();
        drops_before = drop_cnt;
        drive_hits(FRAME_HITS, BIN_RANDOM, '0, 0);
        drive_hits(FRAME_HITS, BIN_RANDOM, '0, 0);
        // keeps hitting while the builder waits for the readout
        drive_hits(40, BIN_RANDOM, '0, 0);
        complete_frame();
        wait_idle();
        if (drop_cnt == drops_before) begin
            $display("no hit was dropped while the readout was busy");
            seq_err_cnt++;
        end
        end_test($sformatf("5 drop during readout, %0d dropped", drop_cnt - drops_before),
                 errs_before);

        errs_before = total_errors();
        for (int f = 0; f < 10; f++) begin
            drive_hits(FRAME_HITS, BIN_RANDOM, '0, 2);
        end
        complete_frame();
        wait_idle();
        end_test("6 long random run", errs_before);

        $display("%0d checks, %0d errors, %0d hits dropped", chk_cnt, total_errors(), drop_cnt);
        if (total_errors() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/hist_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "hist_params.svh"

module hist_top (
    input  wire logic           clk,
    input  wire logic           res,
    input  wire logic           hit_valid,
    input  wire hist_pkg::bin_t hit_bin,
    output logic                hit_drop,
    output logic                frame_done,
    output logic                out_valid,
    output hist_pkg::pixel_t    out_pixel,
    output hist_pkg::bin_t      out_bin,
    output hist_pkg::count_t    out_count,
    output logic                out_last
);

    // builder side of the memory
    logic a_bank;
    hist_pkg::addr_t a_addr;
    logic a_rd_en;
    hist_pkg::count_t a_rd_data;
    logic a_wr_en;
    hist_pkg::addr_t a_wr_addr;
    hist_pkg::count_t a_wr_data;

    // readout side of the memory
    hist_pkg::addr_t b_addr;
    logic b_en;
    hist_pkg::count_t b_rd_data;

    // readout holds off the next swap
    logic rd_busy;

    hist_builder i_hist_builder (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .rd_busy    (rd_busy),
        .a_bank     (a_bank),
        .a_addr     (a_addr),
        .a_rd_en    (a_rd_en),
        .a_rd_data  (a_rd_data),
        .a_wr_en    (a_wr_en),
        .a_wr_addr  (a_wr_addr),
        .a_wr_data  (a_wr_data),
        .frame_done (frame_done),
        .hit_drop   (hit_drop)
    );

    hist_bank_ram i_hist_bank_ram (
        .clk       (clk),
        .res       (res),
        .a_bank    (a_bank),
        .a_addr    (a_addr),
        .a_rd_en   (a_rd_en),
        .a_rd_data (a_rd_data),
        .a_wr_en   (a_wr_en),
        .a_wr_addr (a_wr_addr),
        .a_wr_data (a_wr_data),
        .b_addr    (b_addr),
        .b_en      (b_en),
        .b_rd_data (b_rd_data)
    );

    hist_readout i_hist_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .b_addr     (b_addr),
        .b_en       (b_en),
        .b_rd_data  (b_rd_data),
        .rd_busy    (rd_busy),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_last   (out_last)
    );

endmodule

`default_nettype wire

// File: rtl/hist_readout.sv
`default_nettype none
`timescale 1ns/1ps

`include "hist_params.svh"

module hist_readout (
    input  wire logic             clk,
    input  wire logic             res,
    input  wire logic             frame_done,
    output hist_pkg::addr_t       b_addr,
    output logic                  b_en,
    input  wire hist_pkg::count_t b_rd_data,
    output logic                  rd_busy,
    output logic                  out_valid,
    output hist_pkg::pixel_t      out_pixel,
    output hist_pkg::bin_t        out_bin,
    output hist_pkg::count_t      out_count,
    output logic                  out_last
);

    localparam hist_pkg::addr_t ADDR_LAST =
        hist_pkg::addr_t'(`HIST_PIXEL_NUM * `HIST_BIN_NUM - 1);

    hist_pkg::readout_state_t state_q;

    // sweep address, pixel-major
    hist_pkg::addr_t addr_q;

    // address of the beat now on the output, one memory latency behind
    hist_pkg::addr_t beat_addr_q;

    // one bin per cycle while streaming
    assign b_en = (state_q == hist_pkg::rd_stream);
    assign b_addr = addr_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state_q <= hist_pkg::rd_idle;
            addr_q <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            // beat flags trail the read by the memory latency
            out_valid <= b_en;
            out_last <= b_en && (addr_q == ADDR_LAST);

            case (state_q)
                hist_pkg::rd_idle: begin
                    if (frame_done) begin
                        state_q <= hist_pkg::rd_stream;
                        addr_q <= '0;
                    end
                end
                hist_pkg::rd_stream: begin
                    addr_q <= addr_q + hist_pkg::addr_t'(1);
                    if (addr_q == ADDR_LAST) begin
                        state_q <= hist_pkg::rd_idle;
                    end
                end
                default: begin
                    state_q <= hist_pkg::rd_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        beat_addr_q <= addr_q;
    end

    // split the beat address back into pixel and bin
    assign out_pixel = beat_addr_q[`HIST_BIN_W +: `HIST_PIXEL_W];
    assign out_bin = beat_addr_q[`HIST_BIN_W-1:0];
    assign out_count = b_rd_data;

    // busy while sweeping and through the final beat
    assign rd_busy = b_en || out_valid;

endmodule

`default_nettype wire

// File: rtl/hist_builder.sv
`default_nettype none
`timescale 1ns/1ps

`include "hist_params.svh"

module hist_builder (
    input  wire logic             clk,
    input  wire logic             res,
    input  wire logic             hit_valid,
    input  wire hist_pkg::bin_t   hit_bin,
    input  wire logic             rd_busy,
    output logic                  a_bank,
    output hist_pkg::addr_t       a_addr,
    output logic                  a_rd_en,
    input  wire hist_pkg::count_t a_rd_data,
    output logic                  a_wr_en,
    output hist_pkg::addr_t       a_wr_addr,
    output hist_pkg::count_t      a_wr_data,
    output logic                  frame_done,
    output logic                  hit_drop
);

    localparam hist_pkg::pixel_t PIXEL_LAST = hist_pkg::pixel_t'(`HIST_PIXEL_NUM - 1);
    localparam hist_pkg::acq_t ACQ_LAST = hist_pkg::acq_t'(`HIST_ACQ_NUM - 1);

    hist_pkg::builder_state_t state_q;

    // scan position of the next hit
    hist_pkg::pixel_t pixel_q;
    hist_pkg::acq_t acq_q;

    // pending write bookkeeping for forwarding
    logic wr_bank_q;
    logic fwd_q;
    hist_pkg::count_t wr_data_q;

    // frame_done follows one cycle after an immediate swap
    logic done_pend_q;

    logic accept;
    logic last_hit;
    hist_pkg::count_t cur_count;

    // saturating increment, never wraps back to zero
    function automatic hist_pkg::count_t sat_inc(input hist_pkg::count_t v);
        if (v == '1) begin
            return v;
        end
        return v + hist_pkg::count_t'(1);
    endfunction

    // hits only count while filling
    assign accept = hit_valid && (state_q == hist_pkg::st_fill);
    assign last_hit = accept && (pixel_q == PIXEL_LAST) && (acq_q == ACQ_LAST);

    // read side of the update
    assign a_rd_en = accept;
    assign a_addr = {pixel_q, hit_bin};

    // stale read data when the previous write hit the same bin
    assign cur_count = fwd_q ? wr_data_q : a_rd_data;
    assign a_wr_data = sat_inc(cur_count);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state_q <= hist_pkg::st_fill;
            pixel_q <= '0;
            acq_q <= '0;
            a_bank <= 1'b0;
            a_wr_en <= 1'b0;
            fwd_q <= 1'b0;
            done_pend_q <= 1'b0;
            frame_done <= 1'b0;
            hit_drop <= 1'b0;
        end else begin
            a_wr_en <= accept;
            // forward if this read meets the write landing at the same edge
            fwd_q <= accept && a_wr_en && (a_wr_addr == a_addr) && (wr_bank_q == a_bank);
            hit_drop <= hit_valid && (state_q == hist_pkg::st_wait);
            done_pend_q <= 1'b0;
            frame_done <= done_pend_q;

            case (state_q)
                hist_pkg::st_fill: begin
                    if (accept) begin
                        // pixel steps every hit, round steps on pixel wrap
                        if (pixel_q == PIXEL_LAST) begin
                            pixel_q <= '0;
                            if (acq_q == ACQ_LAST) begin
                                acq_q <= '0;
                            end else begin
                                acq_q <= acq_q + hist_pkg::acq_t'(1);
                            end
                        end else begin
                            pixel_q <= pixel_q + hist_pkg::pixel_t'(1);
                        end
                    end
                    if (last_hit) begin
                        if (rd_busy) begin
                            // other bank still draining
                            state_q <= hist_pkg::st_wait;
                        end else begin
                            // next hit already goes to the fresh bank
                            a_bank <= ~a_bank;
                            done_pend_q <= 1'b1;
                        end
                    end
                end
                hist_pkg::st_wait: begin
                    if (!rd_busy) begin
                        state_q <= hist_pkg::st_fill;
                        a_bank <= ~a_bank;
                        frame_done <= 1'b1;
                    end
                end
                default: begin
                    state_q <= hist_pkg::st_fill;
                end
            endcase
        end
    end

    // write stage payload
    always_ff @(posedge clk) begin
        wr_data_q <= a_wr_data;
        if (accept) begin
            a_wr_addr <= a_addr;
            wr_bank_q <= a_bank;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hist_bank_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "hist_params.svh"

module hist_bank_ram (
    input  wire logic             clk,
    input  wire logic             res,
    input  wire logic             a_bank,
    input  wire hist_pkg::addr_t  a_addr,
    input  wire logic             a_rd_en,
    output hist_pkg::count_t      a_rd_data,
    input  wire logic             a_wr_en,
    input  wire hist_pkg::addr_t  a_wr_addr,
    input  wire hist_pkg::count_t a_wr_data,
    input  wire hist_pkg::addr_t  b_addr,
    input  wire logic             b_en,
    output hist_pkg::count_t      b_rd_data
);

    localparam int DEPTH = `HIST_PIXEL_NUM * `HIST_BIN_NUM;

    // two banks of bin counts
    hist_pkg::count_t mem_q [0:1][0:DEPTH-1];

    // bank seen by the read, reused for the write one cycle later
    logic wr_bank_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // small array, cleared in full
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[0][i] <= '0;
                mem_q[1][i] <= '0;
            end
            wr_bank_q <= 1'b0;
            a_rd_data <= '0;
            b_rd_data <= '0;
        end else begin
            wr_bank_q <= a_bank;
            // builder port, read returns the old value on a collision
            if (a_rd_en) begin
                a_rd_data <= mem_q[a_bank][a_addr];
            end
            if (a_wr_en) begin
                mem_q[wr_bank_q][a_wr_addr] <= a_wr_data;
            end
            // readout port, read and clear the idle bank
            if (b_en) begin
                b_rd_data <= mem_q[~a_bank][b_addr];
                mem_q[~a_bank][b_addr] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/hist_pkg.sv
`default_nettype none

`include "hist_params.svh"

package hist_pkg;

    // timestamp bin of one detection
    typedef logic [`HIST_BIN_W-1:0] bin_t;

    // pixel index and acquisition round index
    typedef logic [`HIST_PIXEL_W-1:0] pixel_t;
    typedef logic [`HIST_ACQ_W-1:0] acq_t;

    // one histogram bin count
    typedef logic [`HIST_COUNT_W-1:0] count_t;

    // address inside one bank, pixel in the upper bits, bin below
    typedef logic [`HIST_PIXEL_W+`HIST_BIN_W-1:0] addr_t;

    // builder fills a bank, or holds while the readout drains
    typedef enum logic {st_fill, st_wait} builder_state_t;

    // readout idle or sweeping the finished bank
    typedef enum logic {rd_idle, rd_stream} readout_state_t;

endpackage

`default_nettype wire

// File: rtl/hist_params.svh
`ifndef HIST_PARAMS_SVH
`define HIST_PARAMS_SVH

// pixels visited per acquisition round, in fixed scan order
`define HIST_PIXEL_NUM 4

// timestamp bins per pixel
`define HIST_BIN_NUM 16

// acquisition rounds per frame
`define HIST_ACQ_NUM 8

// width of one bin count
// kept at 3 so repeated forced bins reach saturation within one frame
`define HIST_COUNT_W 3

// index widths, must cover the counts above
`define HIST_PIXEL_W 2
`define HIST_BIN_W 4
`define HIST_ACQ_W 3

`endif
